//--- common/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// boot rom entry seen as the first fetch out of reset
`define FETCH_RESET_PC       32'hbfc00000
// general exception entry used on flush
`define FETCH_EXC_VECTOR     32'hbfc00380

// direct mapped icache geometry
`define ICACHE_INDEX_BITS    8
`define ICACHE_OFFSET_BITS   4
`define ICACHE_TAG_BITS      (32 - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS)
`define ICACHE_WORD_BITS     (`ICACHE_OFFSET_BITS - 2)   // word select inside a line
`define ICACHE_LINES         (1 << `ICACHE_INDEX_BITS)
`define ICACHE_LINE_WORDS    (1 << `ICACHE_WORD_BITS)

// cp0 cause code for a fetch address error
`define EXC_ADEL             5'd4

`endif

//--- common/fetch_pkg.sv
`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

    // field view of a fetch address as the icache sees it
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0]    tag;     // compared against tag ram
        logic [`ICACHE_INDEX_BITS-1:0]  index;   // selects the line
        logic [`ICACHE_OFFSET_BITS-1:0] offset;  // byte within the line
    } fetch_addr_s;

    // flat for pc arithmetic, fields for the cache lookup
    typedef union packed {
        logic [31:0] flat;
        fetch_addr_s f;
    } fetch_addr_u;

    // exception tag handed to decode with each fetched word
    typedef enum logic [4:0] {
        ADEL = `EXC_ADEL,
        NONE = 5'h1f          // no exception on this item
    } exc_code_e;

endpackage

`default_nettype wire

//--- dv/fetch_checker.sv
`default_nettype none

`include "fetch_config.svh"

module fetch_checker #(
    parameter logic [31:0] word_key = 32'h5a5aa5a5   // memory word is address xor this
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        ds_allowin,
    input  wire logic        br_taken,
    input  wire logic [31:0] br_target,
    input  wire logic        flush,
    input  wire logic        eret,
    input  wire logic [31:0] epc,
    input  wire logic        fs_to_ds_valid,
    input  wire logic [31:0] fs_pc,
    input  wire logic [31:0] fs_inst,
    input  wire logic        fs_ex,
    input  wire logic [4:0]  fs_exc_code,
    input  wire logic        mem_rd_req,
    input  wire logic [31:0] mem_rd_addr,
    output int               consumed,
    output int               errors
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] exp_pc;        // pc the next consumed item must carry
    logic        held;          // item stalled by decode last cycle
    logic [31:0] held_pc;
    logic [31:0] held_inst;
    logic        held_ex;
    logic [4:0]  held_code;
    logic        was_reset;

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, want);
        errors++;
    endtask

    // expected item from the pc alone
    task automatic check_item();
        logic        want_ex;
        logic [31:0] want_inst;
        logic [4:0]  want_code;
        want_ex   = exp_pc[1:0] != 2'b00;               // misaligned fetch is AdEL
        want_inst = want_ex ? 32'd0 : (exp_pc ^ word_key);
        want_code = want_ex ? `EXC_ADEL : 5'h1f;        // all ones means no exception
        if (fs_pc !== exp_pc) begin
            report_mismatch("fs_pc", fs_pc, exp_pc);
        end
        if (fs_inst !== want_inst) begin
            report_mismatch("fs_inst", fs_inst, want_inst);
        end
        if (fs_ex !== want_ex) begin
            report_mismatch("fs_ex", {31'd0, fs_ex}, {31'd0, want_ex});
        end
        if (fs_exc_code !== want_code) begin
            report_mismatch("fs_exc_code", {27'd0, fs_exc_code}, {27'd0, want_code});
        end
    endtask

    // a stalled item must sit still
    task automatic compare_held();
        if (fs_to_ds_valid !== 1'b1) begin
            report_mismatch("fs_to_ds_valid under stall", {31'd0, fs_to_ds_valid}, 32'd1);
        end
        if (fs_pc !== held_pc) report_mismatch("fs_pc under stall", fs_pc, held_pc);
        if (fs_inst !== held_inst) report_mismatch("fs_inst under stall", fs_inst, held_inst);
        if (fs_ex !== held_ex || fs_exc_code !== held_code) begin
            report_mismatch("exception tag under stall", {26'd0, fs_ex, fs_exc_code},
                            {26'd0, held_ex, held_code});
        end
    endtask

    // sampled mid cycle where inputs and outputs have settled
    always @(negedge clk) begin
        if (reset) begin
            exp_pc    = `FETCH_RESET_PC;
            held      = 1'b0;
            was_reset = 1'b1;
            consumed  = 0;
            errors    = 0;
        end else begin
            if (was_reset && (fs_to_ds_valid || mem_rd_req)) begin
                report_mismatch("valid and mem_rd_req after reset",
                                {30'd0, fs_to_ds_valid, mem_rd_req}, 32'd0);
            end
            was_reset = 1'b0;
            if (mem_rd_req && mem_rd_addr[`ICACHE_OFFSET_BITS-1:0] != '0) begin
                report_mismatch("mem_rd_addr alignment", mem_rd_addr, 32'd0);
            end
            if (held) compare_held();
            if (fs_to_ds_valid && ds_allowin) begin       // decode takes it this edge
                check_item();
                consumed++;
                exp_pc = exp_pc + 32'd4;
            end
            if (eret) begin                              // eret over flush over branch
                exp_pc = epc;
            end else if (flush) begin
                exp_pc = `FETCH_EXC_VECTOR;
            end else if (br_taken) begin
                exp_pc = br_target;
            end
            held      = fs_to_ds_valid & ~ds_allowin & ~(eret | flush | br_taken);
            held_pc   = fs_pc;
            held_inst = fs_inst;
            held_ex   = fs_ex;
            held_code = fs_exc_code;
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_fetch.sv
`default_nettype none

`include "fetch_config.svh"

module tb_fetch;
    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    // consumed items per test
    localparam int n_loop   = 60;
    localparam int n_branch = 40;
    localparam int n_exc    = 40;
    localparam int n_adel   = 24;
    localparam int n_stall  = 80;
    localparam int total_items = n_loop + n_branch + n_exc + n_adel + n_stall;
    localparam int cycle_limit = 40 * total_items + 10;     // plus the reset cycles
    localparam logic [31:0] word_key = 32'h5a5aa5a5;

    logic                 clk;
    logic                 reset;
    logic                 ds_allowin;
    logic                 br_taken;
    logic [31:0]          br_target;
    logic                 flush;
    logic                 eret;
    logic [31:0]          epc;
    logic                 fs_to_ds_valid;
    logic [31:0]          fs_pc;
    logic [31:0]          fs_inst;
    logic                 fs_ex;
    exc_code_e            fs_exc_code;
    logic                 mem_rd_req;
    logic [31:0]          mem_rd_addr;
    logic                 mem_rd_valid;
    logic                 mem_rd_last;
    logic [31:0]          mem_rd_data;
    int                   consumed;
    int                   errors;
    int                   tests_done;
    logic                 stall_mode;     // decode back-pressure on

    fetch_top dut0 (.*);

    fetch_checker #(.word_key(word_key)) chk0 (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ word_key;
    endfunction

    // word aligned address near the boot rom
    function automatic logic [31:0] aligned_target(input int span_words);
        return `FETCH_RESET_PC + (($urandom % span_words) << 2);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_items(input int target);
        while (consumed < target) next_cycle();
    endtask

    // one cycle redirect pulse
    task automatic pulse_redirect(input logic b, input logic f, input logic e,
                                  input logic [31:0] target, input logic [31:0] ret_pc);
        br_taken  = b;
        flush     = f;
        eret      = e;
        br_target = target;
        epc       = ret_pc;
        next_cycle();
        br_taken = 1'b0;
        flush    = 1'b0;
        eret     = 1'b0;
    endtask

    task automatic end_test(input string name, input int first_item, input int first_err);
        $display("test %s done: %0d items, %0d errors", name, consumed - first_item,
                 errors - first_err);
        tests_done++;
    endtask

    // decode side stalls at random only in stall mode
    initial begin
        ds_allowin = 1'b1;
        forever begin
            next_cycle();
            ds_allowin = stall_mode ? (($urandom % 3) != 0) : 1'b1;
        end
    end

    // memory answers a refill with four beats in offset order
    initial begin : memory_model
        logic [31:0] line;
        int          gap;
        mem_rd_valid = 1'b0;
        mem_rd_last  = 1'b0;
        mem_rd_data  = 32'd0;
        forever begin
            next_cycle();
            if (mem_rd_req && !reset) begin
                line = mem_rd_addr;
                gap  = 1 + $urandom % 6;
                repeat (gap) next_cycle();
                for (int i = 0; i < 4; i++) begin
                    mem_rd_valid = 1'b1;
                    mem_rd_last  = (i == 3);
                    mem_rd_data  = mem_word(line + 4 * i);
                    next_cycle();
                end
                mem_rd_valid = 1'b0;
                mem_rd_last  = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d items consumed", cycles, consumed,
                 total_items);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int          start;
        int          e0;
        logic [31:0] loop_pc;
        void'($urandom(4149));
        clk        = 1'b0;
        reset      = 1'b1;
        br_taken   = 1'b0;
        br_target  = 32'd0;
        flush      = 1'b0;
        eret       = 1'b0;
        epc        = 32'd0;
        stall_mode = 1'b0;
        tests_done = 0;
        repeat (10) @(posedge clk);
        #2 reset = 1'b0;

        // straight run from reset and then a short loop over the same lines
        start   = consumed;
        e0      = errors;
        loop_pc = aligned_target(64);
        wait_items(start + 20);
        while (consumed < start + n_loop) begin
            pulse_redirect(1'b1, 1'b0, 1'b0, loop_pc, 32'd0);
            wait_items(consumed + 3 + $urandom % 6);
        end
        end_test("loop", start, e0);

        start = consumed;
        e0    = errors;
        while (consumed < start + n_branch) begin
            pulse_redirect(1'b1, 1'b0, 1'b0, aligned_target(16384), 32'd0);
            wait_items(consumed + 2 + $urandom % 5);
        end
        end_test("branch", start, e0);

        start = consumed;
        e0    = errors;
        while (consumed < start + n_exc) begin
            case ($urandom % 4)
                0: pulse_redirect(1'b0, 1'b1, 1'b0, 32'd0, 32'd0);
                1: pulse_redirect(1'b0, 1'b0, 1'b1, 32'd0, aligned_target(16384));
                2: pulse_redirect(1'b0, 1'b1, 1'b1, 32'd0, aligned_target(16384));
                default: pulse_redirect(1'b1, 1'b1, 1'b0, aligned_target(16384), 32'd0);
            endcase
            wait_items(consumed + 2 + $urandom % 4);
        end
        end_test("flush_eret", start, e0);

        // misaligned branch gives an AdEL stream until the next redirect
        start = consumed;
        e0    = errors;
        while (consumed < start + n_adel) begin
            pulse_redirect(1'b1, 1'b0, 1'b0, aligned_target(4096) | (1 + $urandom % 3), 32'd0);
            wait_items(consumed + 3);
            pulse_redirect(1'b1, 1'b0, 1'b0, aligned_target(4096), 32'd0);
            wait_items(consumed + 3);
        end
        end_test("adel", start, e0);

        start      = consumed;
        e0         = errors;
        stall_mode = 1'b1;
        while (consumed < start + n_stall) begin
            case ($urandom % 5)
                0: pulse_redirect(1'b1, 1'b0, 1'b0, aligned_target(4096) | 32'd2, 32'd0);
                1: pulse_redirect(1'b0, 1'b1, 1'b0, 32'd0, 32'd0);
                2: pulse_redirect(1'b0, 1'b0, 1'b1, 32'd0, aligned_target(16384));
                default: pulse_redirect(1'b1, 1'b0, 1'b0, aligned_target(16384), 32'd0);
            endcase
            wait_items(consumed + 2 + $urandom % 6);
        end
        stall_mode = 1'b0;
        end_test("stall", start, e0);

        $display("%0d tests, %0d items, %0d errors", tests_done, consumed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fetch/if_stage.sv
`default_nettype none

`include "fetch_config.svh"

module if_stage (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   ds_allowin,
    input  wire logic                   br_taken,
    input  wire logic [31:0]            br_target,
    input  wire logic                   flush,
    input  wire logic                   eret,
    input  wire logic [31:0]            epc,
    output logic                        inst_valid,
    output fetch_pkg::fetch_addr_u      inst_addr,
    input  wire logic                   inst_addr_ok,
    input  wire logic                   inst_data_ok,
    input  wire logic [31:0]            inst_rdata,
    output logic                        fs_to_ds_valid,
    output logic [31:0]                 fs_pc,
    output logic [31:0]                 fs_inst,
    output logic                        fs_ex,
    output fetch_pkg::exc_code_e        fs_exc_code
);
    import fetch_pkg::*;

    fetch_addr_u fetch_pc;          // address of the next cache request
    fetch_addr_u next_pc;
    logic        fetch_en;          // held low for the first cycle out of reset
    logic        redirect;
    logic        misaligned;
    logic        slot_free;
    logic        accept;
    logic        keep;              // response belongs to the live stream
    logic        adel_go;
    logic        out_free;
    logic        load_out;
    logic [1:0]  out_cnt;           // accepted requests not yet answered
    logic [1:0]  out_cnt_next;
    logic [1:0]  drop_cnt;          // of those, how many are stale
    logic [31:0] resp_pc;           // pc of the next kept response

    // two entry response buffer ahead of the decode register
    logic [31:0] buf_pc   [2];
    logic [31:0] buf_inst [2];
    logic        buf_wr;
    logic        buf_rd;
    logic [1:0]  buf_cnt;

    assign redirect   = eret | flush | br_taken;
    assign misaligned = fetch_pc.flat[1:0] != 2'b00;

    // each request in flight owns a buffer slot so data_ok never stalls
    assign slot_free  = ({1'b0, buf_cnt} + {1'b0, out_cnt}) < 3'd2;
    assign inst_valid = fetch_en & ~misaligned & slot_free;
    assign inst_addr  = fetch_pc;
    assign accept     = inst_valid & inst_addr_ok;

    assign keep     = inst_data_ok & (drop_cnt == 2'd0) & ~redirect;
    assign out_free = ~fs_to_ds_valid | ds_allowin;   // decode register empty or draining
    assign load_out = out_free & (buf_cnt != 2'd0) & ~redirect;
    // bad address skips the cache once older words have drained
    assign adel_go  = fetch_en & misaligned & ~redirect & out_free & (buf_cnt == 2'd0);

    // eret over flush over branch over sequential
    always_comb begin
        if (eret) begin
            next_pc.flat = epc;
        end else if (flush) begin
            next_pc.flat = `FETCH_EXC_VECTOR;
        end else if (br_taken) begin
            next_pc.flat = br_target;
        end else if (accept || adel_go) begin
            next_pc.flat = fetch_pc.flat + 32'd4;
        end else begin
            next_pc = fetch_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc.flat <= `FETCH_RESET_PC;
            fetch_en      <= 1'b0;
        end else begin
            fetch_pc <= next_pc;
            fetch_en <= 1'b1;
        end
    end

    assign out_cnt_next = out_cnt + {1'b0, accept} - {1'b0, inst_data_ok};

    always_ff @(posedge clk) begin
        if (reset) begin
            out_cnt  <= 2'd0;
            drop_cnt <= 2'd0;
        end else begin
            out_cnt <= out_cnt_next;
            if (redirect) begin
                drop_cnt <= out_cnt_next;           // everything still out is old stream
            end else if (inst_data_ok && drop_cnt != 2'd0) begin
                drop_cnt <= drop_cnt - 2'd1;
            end
        end
    end

    // live requests run sequentially from the last redirect
    always_ff @(posedge clk) begin
        if (reset) begin
            resp_pc <= `FETCH_RESET_PC;
        end else if (redirect) begin
            resp_pc <= next_pc.flat;
        end else if (keep || adel_go) begin
            resp_pc <= resp_pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            buf_wr  <= 1'b0;
            buf_rd  <= 1'b0;
            buf_cnt <= 2'd0;
        end else begin
            if (keep) begin
                buf_wr <= ~buf_wr;
            end
            if (load_out) begin
                buf_rd <= ~buf_rd;
            end
            buf_cnt <= buf_cnt + {1'b0, keep} - {1'b0, load_out};
        end
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            buf_pc[buf_wr]   <= resp_pc;
            buf_inst[buf_wr] <= inst_rdata;
        end
    end

    // decode register
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            fs_to_ds_valid <= 1'b0;                  // old stream item dropped
        end else if (load_out || adel_go) begin
            fs_to_ds_valid <= 1'b1;
        end else if (ds_allowin) begin
            fs_to_ds_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            fs_pc       <= buf_pc[buf_rd];
            fs_inst     <= buf_inst[buf_rd];
            fs_ex       <= 1'b0;
            fs_exc_code <= NONE;
        end else if (adel_go) begin
            fs_pc       <= fetch_pc.flat;
            fs_inst     <= 32'd0;                    // no word fetched
            fs_ex       <= 1'b1;
            fs_exc_code <= ADEL;
        end
    end

    // the cache never sees a misaligned request
    a_req_aligned: assert property (@(posedge clk) disable iff (reset)
        inst_valid |-> inst_addr.flat[1:0] == 2'b00);

    // in flight plus buffered stays within the two slots
    a_slots: assert property (@(posedge clk) disable iff (reset)
        ({1'b0, out_cnt} + {1'b0, buf_cnt}) <= 3'd2);

endmodule

`default_nettype wire

//--- icache/icache.sv
`default_nettype none

`include "fetch_config.svh"

module icache (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   inst_valid,
    input  wire fetch_pkg::fetch_addr_u inst_addr,
    output logic                        inst_addr_ok,
    output logic                        inst_data_ok,
    output logic [31:0]                 inst_rdata,
    output logic                        mem_rd_req,
    output logic [31:0]                 mem_rd_addr,
    input  wire logic                   mem_rd_valid,
    input  wire logic                   mem_rd_last,
    input  wire logic [31:0]            mem_rd_data
);
    import fetch_pkg::*;

    // line storage
    logic [`ICACHE_TAG_BITS-1:0] tag_ram  [`ICACHE_LINES];
    logic [31:0]                 data_ram [`ICACHE_LINES * `ICACHE_LINE_WORDS];
    logic [`ICACHE_LINES-1:0]    valid_bits;

    // lookup register holding the accepted request
    fetch_addr_u                  req_addr;
    logic                         req_vld;

    // refill FSM, idle or refilling
    logic                         refilling;
    logic [`ICACHE_WORD_BITS-1:0] beat;       // next word of the line to write

    logic                         hit;
    logic                         miss;
    logic                         beat_wr;
    logic [1:0]                   pend_cnt;   // accepted and not yet answered

    logic [`ICACHE_INDEX_BITS-1:0] req_index;
    logic [`ICACHE_WORD_BITS-1:0]  req_word;

    assign req_index = req_addr.f.index;
    assign req_word  = req_addr.f.offset[`ICACHE_OFFSET_BITS-1:2];

    // response stage compares the registered request
    assign hit  = req_vld & ~refilling & valid_bits[req_index]
                & (tag_ram[req_index] == req_addr.f.tag);
    assign miss = req_vld & ~refilling & ~hit;

    // take a new request when the slot is empty or answering now
    assign inst_addr_ok = inst_valid & ~refilling & (~req_vld | hit);
    assign inst_data_ok = hit;
    assign inst_rdata   = data_ram[{req_index, req_word}];

    assign beat_wr     = refilling & mem_rd_valid;
    assign mem_rd_req  = refilling;
    assign mem_rd_addr = {req_addr.f.tag, req_index, {`ICACHE_OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (reset) begin
            req_vld <= 1'b0;
        end else if (inst_addr_ok) begin
            req_vld <= 1'b1;
        end else if (hit) begin
            req_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_addr_ok) begin
            req_addr <= inst_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            refilling <= 1'b0;
            beat      <= '0;
        end else if (miss) begin
            refilling <= 1'b1;                       // request line from memory
            beat      <= '0;
        end else if (beat_wr) begin
            beat <= beat + 1'b1;
            if (mem_rd_last) begin
                refilling <= 1'b0;                   // waiting request hits next cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (miss) begin
            valid_bits[req_index] <= 1'b0;           // line under replacement
        end else if (beat_wr && mem_rd_last) begin
            valid_bits[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_wr) begin
            data_ram[{req_index, beat}] <= mem_rd_data;
            if (mem_rd_last) begin
                tag_ram[req_index] <= req_addr.f.tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_cnt <= 2'd0;
        end else begin
            pend_cnt <= pend_cnt + {1'b0, inst_addr_ok} - {1'b0, inst_data_ok};
        end
    end

    // memory only answers a refill in progress
    a_mem_in_refill: assert property (@(posedge clk) disable iff (reset)
        mem_rd_valid |-> mem_rd_req);

    // last flag lands on the final word of the line
    a_last_beat: assert property (@(posedge clk) disable iff (reset)
        (mem_rd_valid && mem_rd_last) |-> beat == {`ICACHE_WORD_BITS{1'b1}});

    // every data_ok answers some earlier accepted request
    a_data_ok_pending: assert property (@(posedge clk) disable iff (reset)
        inst_data_ok |-> pend_cnt != 2'd0);

endmodule

`default_nettype wire

//--- logic/fetch_top.sv
`default_nettype none

module fetch_top (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             ds_allowin,
    input  wire logic             br_taken,
    input  wire logic [31:0]      br_target,
    input  wire logic             flush,
    input  wire logic             eret,
    input  wire logic [31:0]      epc,
    output logic                  fs_to_ds_valid,
    output logic [31:0]           fs_pc,
    output logic [31:0]           fs_inst,
    output logic                  fs_ex,
    output fetch_pkg::exc_code_e  fs_exc_code,
    output logic                  mem_rd_req,
    output logic [31:0]           mem_rd_addr,
    input  wire logic             mem_rd_valid,
    input  wire logic             mem_rd_last,
    input  wire logic [31:0]      mem_rd_data
);
    import fetch_pkg::*;

    // fetch to cache request and response
    logic        inst_valid;
    fetch_addr_u inst_addr;
    logic        inst_addr_ok;
    logic        inst_data_ok;
    logic [31:0] inst_rdata;

    if_stage u_if_stage (
        .clk            (clk),
        .reset          (reset),
        .ds_allowin     (ds_allowin),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .flush          (flush),
        .eret           (eret),
        .epc            (epc),
        .inst_valid     (inst_valid),
        .inst_addr      (inst_addr),
        .inst_addr_ok   (inst_addr_ok),
        .inst_data_ok   (inst_data_ok),
        .inst_rdata     (inst_rdata),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .fs_ex          (fs_ex),
        .fs_exc_code    (fs_exc_code)
    );

    icache u_icache (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_last  (mem_rd_last),
        .mem_rd_data  (mem_rd_data)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module tb_fetch \
    -Mdir obj_dir -o sim_fetch

./obj_dir/sim_fetch 2>&1 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"

//--- sources.f
+incdir+common
common/fetch_pkg.sv
fetch/if_stage.sv
icache/icache.sv
logic/fetch_top.sv
dv/fetch_checker.sv
dv/tb_fetch.sv
